//--- verilog/dai_cfg.svh
`ifndef DAI_CFG_SVH
`define DAI_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Audio interface sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// One audio word on the serial line
`define DAI_SAMPLE_W 16

// Master-clock position in a frame, the longest frame is 1088 clocks
`define DAI_FRAME_CNT_W 11

// Bit-clock position in a half frame, saturates well past the sample width
`define DAI_BIT_CNT_W 9

// Flops in front of the external bit and word clocks in slave mode
`define DAI_SYNC_STAGES 2

`endif

//--- verilog/dai_pkg.sv
package dai_pkg;

`include "dai_cfg.svh"

  // Two's complement audio word, sent MSB first
  typedef logic [`DAI_SAMPLE_W-1:0] sample_t;

  // Master-clock count inside one stereo frame
  typedef logic [`DAI_FRAME_CNT_W-1:0] frame_cnt_t;

  // Bit index inside one channel half of the frame
  typedef logic [`DAI_BIT_CNT_W-1:0] bit_cnt_t;

  // Frame mode select
  //   7 -> 256 clocks, bclk /4    6 -> 128 clocks, bclk /2
  //   5 -> 272 clocks, bclk /4    4 -> 136 clocks, bclk /2
  //   3 -> 1024 clocks, bclk /4   2 -> 512 clocks, bclk /4
  //   1 -> 1088 clocks, bclk /4   0 -> 544 clocks, bclk /4
  typedef logic [2:0] mclk_mode_t;

endpackage

//--- verilog/dai_bit_if.sv
`timescale 1ns/100ps

interface dai_bit_if;

  // Bit-clock edges as single-cycle enables in the master-clock domain
  logic bclk_rise;
  logic bclk_fall;

  // Word-clock level now and as it was at the last bit-clock rise
  // Low selects the left channel
  logic lrc;
  logic lrc_prev;

  modport source (
    output bclk_rise,
    output bclk_fall,
    output lrc,
    output lrc_prev
  );

  modport rx_sink (
    input bclk_rise,
    input lrc,
    input lrc_prev
  );

  modport tx_sink (
    input bclk_rise,
    input bclk_fall,
    input lrc,
    input lrc_prev
  );

endinterface

//--- verilog/dai_clk_gen.sv
`timescale 1ns/100ps

module dai_clk_gen (
  input  logic                RESET,
  input  logic                bclk_ok,
  input  logic                master_i,
  input  dai_pkg::mclk_mode_t mode_i,
  output logic                bclk_o,
  output logic                lrclk_o,
  dai_bit_if.source           bits
);
  import dai_pkg::*;

  frame_cnt_t frame_cnt_q;
  frame_cnt_t frame_len;
  frame_cnt_t frame_last;
  frame_cnt_t half_last;
  logic       div4;
  logic       bclk_toggle;
  logic       frame_wrap;
  logic       bclk_rise_q;
  logic       bclk_fall_q;
  logic       lrc_prev_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Mode decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    div4 = 1'b1;
    case (mode_i)
      3'd7: frame_len = frame_cnt_t'(256);
      3'd6: begin
        frame_len = frame_cnt_t'(128);
        div4      = 1'b0;
      end
      3'd5: frame_len = frame_cnt_t'(272);
      3'd4: begin
        frame_len = frame_cnt_t'(136);
        div4      = 1'b0;
      end
      3'd3: frame_len = frame_cnt_t'(1024);
      3'd2: frame_len = frame_cnt_t'(512);
      3'd1: frame_len = frame_cnt_t'(1088);
      default: frame_len = frame_cnt_t'(544);
    endcase
  end

  assign frame_last  = frame_len - 1'b1;
  assign half_last   = (frame_len >> 1) - 1'b1;
  assign frame_wrap  = (frame_cnt_q >= frame_last);
  // Divide by 4 toggles on odd counts so word-clock changes meet a falling bclk
  assign bclk_toggle = !div4 || frame_cnt_q[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame counter and clock outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok || !master_i) begin
      frame_cnt_q <= '0;
      bclk_o      <= 1'b0;
      lrclk_o     <= 1'b0;
      bclk_rise_q <= 1'b0;
      bclk_fall_q <= 1'b0;
      lrc_prev_q  <= 1'b0;
    end else begin
      frame_cnt_q <= frame_wrap ? '0 : frame_cnt_q + 1'b1;
      bclk_o      <= bclk_o ^ bclk_toggle;
      bclk_rise_q <= bclk_toggle && !bclk_o;
      bclk_fall_q <= bclk_toggle && bclk_o;
      if (frame_wrap) begin
        lrclk_o <= 1'b0;
      end else if (frame_cnt_q == half_last) begin
        lrclk_o <= 1'b1;
      end
      if (bclk_rise_q) begin
        lrc_prev_q <= lrclk_o;
      end
    end
  end

  assign bits.bclk_rise = bclk_rise_q;
  assign bits.bclk_fall = bclk_fall_q;
  assign bits.lrc       = lrclk_o;
  assign bits.lrc_prev  = lrc_prev_q;

endmodule

//--- verilog/dai_slave_sync.sv
`timescale 1ns/100ps

module dai_slave_sync (
  input  logic      RESET,
  input  logic      bclk_ok,
  input  logic      master_i,
  input  logic      bclk_i,
  input  logic      lrclk_i,
  dai_bit_if.source bits
);

`include "dai_cfg.svh"

  logic [`DAI_SYNC_STAGES-1:0] bclk_sync_q;
  logic [`DAI_SYNC_STAGES-1:0] lrclk_sync_q;
  logic                        bclk_s;
  logic                        bclk_d_q;
  logic                        bclk_rise_q;
  logic                        bclk_fall_q;
  logic                        lrc_q;
  logic                        lrc_prev_q;

  assign bclk_s = bclk_sync_q[`DAI_SYNC_STAGES-1];

  // The edge strobes and the word-clock level leave one flop after the synchronizer
  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok || master_i) begin
      bclk_sync_q  <= '0;
      lrclk_sync_q <= '0;
      bclk_d_q     <= 1'b0;
      bclk_rise_q  <= 1'b0;
      bclk_fall_q  <= 1'b0;
      lrc_q        <= 1'b0;
      lrc_prev_q   <= 1'b0;
    end else begin
      bclk_sync_q  <= {bclk_sync_q[`DAI_SYNC_STAGES-2:0], bclk_i};
      lrclk_sync_q <= {lrclk_sync_q[`DAI_SYNC_STAGES-2:0], lrclk_i};
      bclk_d_q     <= bclk_s;
      bclk_rise_q  <= bclk_s && !bclk_d_q;
      bclk_fall_q  <= !bclk_s && bclk_d_q;
      lrc_q        <= lrclk_sync_q[`DAI_SYNC_STAGES-1];
      if (bclk_rise_q) begin
        lrc_prev_q <= lrc_q;
      end
    end
  end

  assign bits.bclk_rise = bclk_rise_q;
  assign bits.bclk_fall = bclk_fall_q;
  assign bits.lrc       = lrc_q;
  assign bits.lrc_prev  = lrc_prev_q;

endmodule

//--- verilog/dai_rx.sv
`timescale 1ns/100ps

module dai_rx (
  input  logic             RESET,
  input  logic             bclk_ok,
  input  logic             din_i,
  dai_bit_if.rx_sink       bits,
  output dai_pkg::sample_t dac_left_o,
  output dai_pkg::sample_t dac_right_o,
  output logic             frame_valid_o
);
  import dai_pkg::*;

`include "dai_cfg.svh"

  bit_cnt_t bit_cnt_q;
  bit_cnt_t bit_idx;
  sample_t  shift_q;
  sample_t  rx_word;
  logic     word_done;

  // Index of the current rise, 0 on a word-clock change, saturating past the word
  always_comb begin
    if (bits.lrc != bits.lrc_prev) begin
      bit_idx = '0;
    end else if (bit_cnt_q == '1) begin
      bit_idx = bit_cnt_q;
    end else begin
      bit_idx = bit_cnt_q + 1'b1;
    end
  end

  assign rx_word   = {shift_q[`DAI_SAMPLE_W-2:0], din_i};
  assign word_done = bits.bclk_rise && (bit_idx == bit_cnt_t'(`DAI_SAMPLE_W));

  always_ff @(posedge RESET) begin
    if (bits.bclk_rise) begin
      shift_q <= rx_word;
    end
  end

  // Counter starts saturated so nothing is stored before the first word-clock change
  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      bit_cnt_q     <= '1;
      dac_left_o    <= '0;
      dac_right_o   <= '0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= word_done && bits.lrc;
      if (bits.bclk_rise) begin
        bit_cnt_q <= bit_idx;
      end
      if (word_done && bits.lrc) begin
        dac_right_o <= rx_word;
      end else if (word_done) begin
        dac_left_o <= rx_word;
      end
    end
  end

endmodule

//--- verilog/dai_tx.sv
`timescale 1ns/100ps

module dai_tx (
  input  logic             RESET,
  input  logic             bclk_ok,
  input  logic             loopback_i,
  input  dai_pkg::sample_t adc_left_i,
  input  dai_pkg::sample_t adc_right_i,
  input  dai_pkg::sample_t dac_left_i,
  input  dai_pkg::sample_t dac_right_i,
  dai_bit_if.tx_sink       bits,
  output logic             dout_o
);
  import dai_pkg::*;

`include "dai_cfg.svh"

  bit_cnt_t bit_cnt_q;
  sample_t  shift_q;
  sample_t  tx_word;

  always_comb begin
    if (loopback_i) begin
      tx_word = bits.lrc ? dac_right_i : dac_left_i;
    end else begin
      tx_word = bits.lrc ? adc_right_i : adc_left_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit position on rises, data out on falls
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge RESET or posedge bclk_ok) begin
    if (bclk_ok) begin
      bit_cnt_q <= '1;
      dout_o    <= 1'b0;
    end else begin
      if (bits.bclk_rise && (bits.lrc != bits.lrc_prev)) begin
        bit_cnt_q <= '0;
      end else if (bits.bclk_rise && (bit_cnt_q != '1)) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      // The fall after index 0 carries the MSB, the line idles low after the LSB
      if (bits.bclk_fall) begin
        if (bit_cnt_q == '0) begin
          dout_o <= tx_word[`DAI_SAMPLE_W-1];
        end else if (bit_cnt_q < bit_cnt_t'(`DAI_SAMPLE_W)) begin
          dout_o <= shift_q[`DAI_SAMPLE_W-1];
        end else begin
          dout_o <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge RESET) begin
    if (bits.bclk_fall) begin
      shift_q <= (bit_cnt_q == '0) ? (tx_word << 1) : (shift_q << 1);
    end
  end

endmodule

//--- verilog/dai_top.sv
`timescale 1ns/100ps

module dai_top (
  input  logic                RESET,
  input  logic                bclk_ok,
  input  logic                master_i,
  input  dai_pkg::mclk_mode_t mode_i,
  input  logic                bclk_i,
  input  logic                lrclk_i,
  input  logic                din_i,
  input  logic                loopback_i,
  input  dai_pkg::sample_t    adc_left_i,
  input  dai_pkg::sample_t    adc_right_i,
  output logic                bclk_o,
  output logic                lrclk_o,
  output logic                dout_o,
  output dai_pkg::sample_t    dac_left_o,
  output dai_pkg::sample_t    dac_right_o,
  output logic                frame_valid_o
);

  dai_bit_if master_bus ();
  dai_bit_if slave_bus ();
  dai_bit_if data_bus ();

  dai_clk_gen u_clk_gen (
    .RESET    (RESET),
    .bclk_ok  (bclk_ok),
    .master_i (master_i),
    .mode_i   (mode_i),
    .bclk_o   (bclk_o),
    .lrclk_o  (lrclk_o),
    .bits     (master_bus.source)
  );

  dai_slave_sync u_slave_sync (
    .RESET    (RESET),
    .bclk_ok  (bclk_ok),
    .master_i (master_i),
    .bclk_i   (bclk_i),
    .lrclk_i  (lrclk_i),
    .bits     (slave_bus.source)
  );

  // Only the selected timing block is running, the other one sits in reset
  assign data_bus.bclk_rise = master_i ? master_bus.bclk_rise : slave_bus.bclk_rise;
  assign data_bus.bclk_fall = master_i ? master_bus.bclk_fall : slave_bus.bclk_fall;
  assign data_bus.lrc       = master_i ? master_bus.lrc       : slave_bus.lrc;
  assign data_bus.lrc_prev  = master_i ? master_bus.lrc_prev  : slave_bus.lrc_prev;

  dai_rx u_rx (
    .RESET         (RESET),
    .bclk_ok       (bclk_ok),
    .din_i         (din_i),
    .bits          (data_bus.rx_sink),
    .dac_left_o    (dac_left_o),
    .dac_right_o   (dac_right_o),
    .frame_valid_o (frame_valid_o)
  );

  dai_tx u_tx (
    .RESET       (RESET),
    .bclk_ok     (bclk_ok),
    .loopback_i  (loopback_i),
    .adc_left_i  (adc_left_i),
    .adc_right_i (adc_right_i),
    .dac_left_i  (dac_left_o),
    .dac_right_i (dac_right_o),
    .bits        (data_bus.tx_sink),
    .dout_o      (dout_o)
  );

endmodule

//--- verification/dai_props.sv
`timescale 1ns/100ps

module dai_props (
  input logic RESET,
  input logic bclk_ok,
  input logic master_i,
  input logic bclk_o,
  input logic lrclk_o,
  input logic dout_o,
  input logic frame_valid_o
);

  // A stereo frame is marked by a single-cycle strobe
  frame_valid_pulse: assert property (
    @(posedge RESET) disable iff (bclk_ok)
    frame_valid_o |=> !frame_valid_o
  ) else $error("frame_valid_o held high for more than one cycle");

  // The divider is held in reset one cycle after slave mode is selected
  slave_clocks_low: assert property (
    @(posedge RESET) disable iff (bclk_ok)
    (!master_i ##1 !master_i) |-> (!bclk_o && !lrclk_o)
  ) else $error("bclk_o or lrclk_o active in slave mode");

  dout_low_in_reset: assert property (
    @(posedge RESET) bclk_ok |-> !dout_o
  ) else $error("dout_o not low during reset");

endmodule

bind dai_top dai_props props_i (
  .RESET         (RESET),
  .bclk_ok       (bclk_ok),
  .master_i      (master_i),
  .bclk_o        (bclk_o),
  .lrclk_o       (lrclk_o),
  .dout_o        (dout_o),
  .frame_valid_o (frame_valid_o)
);

//--- verification/dai_tb.sv
`timescale 1ns/100ps

module dai_tb;
  import dai_pkg::*;

  // Three passes over every frame length plus the slave and master frames
  localparam int watchdog_cycles = 2 * (3 * 3960 + 8 * 400 + 8 * 256 + 200);

  logic       RESET;
  logic       bclk_ok;
  logic       master_i;
  mclk_mode_t mode_i;
  logic       bclk_i;
  logic       lrclk_i;
  logic       din_i;
  logic       loopback_i;
  sample_t    adc_left_i;
  sample_t    adc_right_i;
  logic       bclk_o;
  logic       lrclk_o;
  logic       dout_o;
  sample_t    dac_left_o;
  sample_t    dac_right_o;
  logic       frame_valid_o;

  integer  seed;
  int      checks;
  int      errors;
  int      test_start;
  int      fv_count;
  sample_t cap_left;
  sample_t cap_right;

  dai_top dut_i (.*);

  initial begin
    RESET = 1'b0;
    forever #50 RESET = ~RESET;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge RESET);
    $display("Run timed out after %0d clock cycles", watchdog_cycles);
    $display("Test failed");
    $finish;
  end

  // Keeps the samples of the last completed stereo frame
  always @(negedge RESET) begin
    if (frame_valid_o) begin
      fv_count  = fv_count + 1;
      cap_left  = dac_left_o;
      cap_right = dac_right_o;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t: %s, expected %h, got %h", $time, msg, expected, actual);
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s finished with %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Slave bus driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One bit clock lasts 8 master clocks and the data and word clock change on its fall
  task automatic drive_slave_bit(input logic lr, input logic d);
    @(negedge RESET);
    bclk_i  = 1'b0;
    lrclk_i = lr;
    din_i   = d;
    for (int i = 0; i < 8; i++) begin
      if (i == 4) bclk_i = 1'b1;
      check({bclk_o, lrclk_o}, 2'b00, "bclk_o and lrclk_o in slave mode");
      if (i < 7) @(negedge RESET);
    end
  endtask

  task automatic drive_slave_frame(input sample_t l, input sample_t r);
    for (int k = 0; k < 20; k++) begin
      drive_slave_bit(1'b0, (k >= 1 && k <= 16) ? l[16-k] : 1'b0);
    end
    for (int k = 0; k < 20; k++) begin
      drive_slave_bit(1'b1, (k >= 1 && k <= 16) ? r[16-k] : 1'b0);
    end
  endtask

  task automatic wait_frame_valid(input int target);
    int n;
    n = 0;
    while (fv_count < target && n < 200) begin
      @(negedge RESET);
      n++;
    end
    if (fv_count < target) begin
      $display("No frame_valid_o pulse seen after the slave frame");
      errors = errors + 1;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Master mode monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Clocks between two rising edges of lrclk_o or bclk_o
  task automatic rise_gap(input bit use_lr, output int gap);
    logic prev;
    logic cur;
    int   n;
    int   seen;
    seen = 0;
    gap  = 0;
    n    = 0;
    prev = use_lr ? lrclk_o : bclk_o;
    while (seen < 2 && n < 3000) begin
      @(negedge RESET);
      n++;
      cur = use_lr ? lrclk_o : bclk_o;
      if (seen == 1) gap++;
      if (cur && !prev) seen++;
      prev = cur;
    end
    if (seen < 2) begin
      $display("No second rising edge seen on %s", use_lr ? "lrclk_o" : "bclk_o");
      errors = errors + 1;
    end
  endtask

  // Drives din_i and rebuilds the dout_o words of one left and right half by bit index
  task automatic run_master_frame(input sample_t din_l, input sample_t din_r,
                                  output sample_t got_l,
                                  output sample_t got_r);
    int      idx;
    int      n;
    logic    lr_last;
    logic    prev_b;
    bit      started;
    bit      have_l;
    bit      done;
    sample_t word;
    idx     = 99;
    n       = 0;
    lr_last = lrclk_o;
    prev_b  = bclk_o;
    started = 0;
    have_l  = 0;
    done    = 0;
    word    = '0;
    got_l   = '0;
    got_r   = '0;
    while (!done && n < 4000) begin
      @(negedge RESET);
      n++;
      if (bclk_o && !prev_b) begin
        if (lrclk_o != lr_last) idx = 0;
        else if (idx < 99) idx++;
        lr_last = lrclk_o;
        if (idx == 0 && !lrclk_o) started = 1;
        if (idx >= 1 && idx <= 16) begin
          din_i = lrclk_o ? din_r[16-idx] : din_l[16-idx];
          word  = {word[14:0], dout_o};
        end else begin
          din_i = 1'b0;
        end
        if (started && idx == 16 && !lrclk_o) begin
          got_l  = word;
          have_l = 1;
        end else if (have_l && idx == 16 && lrclk_o) begin
          got_r = word;
          done  = 1;
        end
      end
      prev_b = bclk_o;
    end
    if (!done) begin
      $display("Timed out waiting for a left and right word on dout_o");
      errors = errors + 1;
    end
  endtask

  function automatic int frame_len_of(input int m);
    case (m)
      7: return 256;
      6: return 128;
      5: return 272;
      4: return 136;
      3: return 1024;
      2: return 512;
      1: return 1088;
      default: return 544;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_test();
    for (int i = 0; i < 5; i++) begin
      @(negedge RESET);
      if (i == 4) bclk_ok = 1'b0;
      check({bclk_o, lrclk_o, dout_o, frame_valid_o}, 4'h0, "control outputs after reset");
      check({dac_left_o, dac_right_o}, 32'h0, "DAC samples after reset");
    end
    @(negedge RESET);
    check({bclk_o, lrclk_o, dout_o, frame_valid_o}, 4'h0, "control outputs right after reset");
    check({dac_left_o, dac_right_o}, 32'h0, "DAC samples right after reset");
    finish_test("reset");
  endtask

  task automatic slave_receive_test();
    sample_t l;
    sample_t r;
    for (int k = 0; k < 4; k++) drive_slave_bit(1'b1, 1'b0);
    for (int f = 0; f < 4; f++) begin
      l = $random(seed);
      r = $random(seed);
      drive_slave_frame(l, r);
      wait_frame_valid(f + 1);
      check(cap_left, l, "dac_left_o after slave frame");
      check(cap_right, r, "dac_right_o after slave frame");
    end
    finish_test("slave receive");
  endtask

  task automatic slave_outputs_test();
    drive_slave_frame(16'h0, 16'h0);
    finish_test("slave outputs");
  endtask

  task automatic master_clock_test();
    int gap;
    @(negedge RESET);
    master_i = 1'b1;
    for (int m = 7; m >= 0; m--) begin
      @(negedge RESET);
      mode_i = m;
      rise_gap(1'b1, gap);
      check(gap, frame_len_of(m), $sformatf("frame length in mode %0d", m));
      rise_gap(1'b0, gap);
      check(gap, (m == 6 || m == 4) ? 2 : 4, $sformatf("bclk_o period in mode %0d", m));
    end
    finish_test("master clocking");
  endtask

  task automatic master_transmit_test();
    sample_t got_l;
    sample_t got_r;
    @(negedge RESET);
    mode_i = 3'd6;
    for (int f = 0; f < 3; f++) begin
      adc_left_i  = $random(seed);
      adc_right_i = $random(seed);
      run_master_frame(16'h0, 16'h0, got_l, got_r);
      check(got_l, adc_left_i, "left word on dout_o");
      check(got_r, adc_right_i, "right word on dout_o");
    end
    finish_test("master transmit");
  endtask

  task automatic loopback_test();
    sample_t got_l;
    sample_t got_r;
    sample_t prev_l;
    sample_t prev_r;
    sample_t l;
    sample_t r;
    loopback_i = 1'b1;
    prev_l     = $random(seed);
    prev_r     = $random(seed);
    run_master_frame(prev_l, prev_r, got_l, got_r);
    for (int f = 0; f < 3; f++) begin
      l = $random(seed);
      r = $random(seed);
      run_master_frame(l, r, got_l, got_r);
      check(got_l, prev_l, "looped back left word");
      check(got_r, prev_r, "looped back right word");
      prev_l = l;
      prev_r = r;
    end
    finish_test("loopback");
  endtask

  initial begin
    seed        = 32'h313eca47;
    checks      = 0;
    errors      = 0;
    test_start  = 0;
    fv_count    = 0;
    bclk_ok     = 1'b1;
    master_i    = 1'b0;
    mode_i      = '0;
    bclk_i      = 1'b0;
    lrclk_i     = 1'b0;
    din_i       = 1'b0;
    loopback_i  = 1'b0;
    adc_left_i  = '0;
    adc_right_i = '0;
    reset_test();
    slave_receive_test();
    slave_outputs_test();
    master_clock_test();
    master_transmit_test();
    loopback_test();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dai.f
+incdir+verilog
verilog/dai_pkg.sv
verilog/dai_bit_if.sv
verilog/dai_clk_gen.sv
verilog/dai_slave_sync.sv
verilog/dai_rx.sv
verilog/dai_tx.sv
verilog/dai_top.sv
verification/dai_props.sv
verification/dai_tb.sv

//--- Bender.yml
package:
  name: dai

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dai_pkg.sv
      - verilog/dai_bit_if.sv
      - verilog/dai_clk_gen.sv
      - verilog/dai_slave_sync.sv
      - verilog/dai_rx.sv
      - verilog/dai_tx.sv
      - verilog/dai_top.sv
  - target: test
    files:
      - verification/dai_props.sv
      - verification/dai_tb.sv
